//--- all.f
+incdir+testbench
design/sa_data_pkg.sv
design/sa_cfg_pkg.sv
design/tile_ctrl.sv
design/operand_skew.sv
design/pe_row.sv
design/ofm_writer.sv
design/sa_core.sv
testbench/tb_sa_core.sv

//--- run.sh
#!/bin/sh
# Build and run the tile engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_sa_core \
  -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_sa_core > sim.log 2>&1 || { cat sim.log; echo "Run failed"; exit 1; }
cat sim.log
grep -q "^PASS: all tests$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- testbench/sa_model.svh
// Tile engine reference model
`ifndef SA_MODEL_SVH
`define SA_MODEL_SVH

// ========================================
// Operand memories
// ========================================
act_t [NUM_ROW-1:0] act_mem [2**ADDR_WIDTH];  // One word per depth step
wgt_t [NUM_COL-1:0] wgt_mem [2**ADDR_WIDTH];

// Random words for the K steps of one tile with wrapping addresses
task automatic fill_operands(input addr_t act_base, input addr_t wgt_base, input int depth);
  for (int k = 0; k < depth; k++) begin
    for (int r = 0; r < NUM_ROW; r++) begin
      act_mem[act_base + addr_t'(k)][r] = act_t'($urandom);
    end
    for (int c = 0; c < NUM_COL; c++) begin
      wgt_mem[wgt_base + addr_t'(k)][c] = wgt_t'($urandom);
    end
  end
endtask

// Full-precision sum of products for one output cell
function automatic longint dot_product(input addr_t act_base, input addr_t wgt_base,
                                       input int depth, input int r, input int c);
  longint sum;
  sum = 0;
  for (int k = 0; k < depth; k++) begin
    sum += longint'(act_mem[act_base + addr_t'(k)][r]) *
           longint'(wgt_mem[wgt_base + addr_t'(k)][c]);
  end
  return sum;
endfunction

// Scale, shift right, add zero point, clamp to 8 bits
function automatic ofm_t requantize(input longint acc, input int scale, input int shift,
                                    input int zp);
  longint val;
  val = ((acc * scale) >>> shift) + zp;
  if (val > 127) begin
    val = 127;
  end else if (val < -128) begin
    val = -128;
  end
  return ofm_t'(val);
endfunction

`endif

//--- testbench/tb_sa_core.sv
// Tile engine testbench
`timescale 1ns/10ps

module tb_sa_core import sa_data_pkg::*, sa_cfg_pkg::*; ();

  localparam int NUM_ROW   = 4;
  localparam int NUM_COL   = 4;
  localparam int NUM_TILES = 20;
  localparam int TILE_CYC  = 400;  // Bound for one tile incl. gaps and stalls
  localparam int LIMIT_CYC = NUM_TILES * TILE_CYC;

  logic clk, rst_n, cfg_vld_i, cfg_rdy_o, rd_addr_vld_o, dat_vld_i, dat_rdy_o;
  logic ofm_vld_o, ofm_rdy_i;
  chi_t cfg_chi_i;
  scale_t cfg_scale_i;
  shift_t cfg_shift_i;
  zp_t cfg_zp_i;
  addr_t cfg_act_base_i, cfg_wgt_base_i, cfg_ofm_base_i;
  addr_t act_rd_addr_o, wgt_rd_addr_o, ofm_addr_o;
  act_t [NUM_ROW-1:0] act_dat_i;
  wgt_t [NUM_COL-1:0] wgt_dat_i;
  ofm_t [NUM_COL-1:0] ofm_dat_o;

  `include "sa_model.svh"

  // Current tile and its expected rows
  int    cur_k;
  addr_t cur_act_base, cur_wgt_base, cur_ofm_base;
  ofm_t  exp_row [NUM_ROW][NUM_COL];
  addr_t act_q [$];  // Issued addresses awaiting data
  addr_t wgt_q [$];

  bit    tile_active, beat_taken, hold_pending, exp_strobe, exp_rdy;
  int    since, rows_seen, beats_seen, cyc;
  int    tiles_done = 0;
  addr_t held_addr;
  ofm_t [NUM_COL-1:0] held_dat;
  int    addr_errs = 0, ofm_errs = 0, flag_errs = 0, other_errs = 0;

  sa_core #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) sa_core_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      addr_errs++;
    end
  endtask

  task automatic check_ofm(input string name, input ofm_t got, input ofm_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      ofm_errs++;
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      flag_errs++;
    end
  endtask

  // ========================================
  // Monitor sampled before the edge updates
  // ========================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (cfg_vld_i && cfg_rdy_o) begin
        tile_active = 1'b1;
        since       = 0;
        rows_seen   = 0;
        beats_seen  = 0;
      end else if (tile_active) begin
        since++;
        check_flag("cfg_rdy_o", cfg_rdy_o, 1'b0);  // Busy until last row
      end
      exp_strobe = tile_active && since >= 1 && since <= cur_k;
      check_flag("rd_addr_vld_o", rd_addr_vld_o, exp_strobe);
      if (exp_strobe) begin
        check_addr("act_rd_addr_o", act_rd_addr_o, cur_act_base + addr_t'(since - 1));
        check_addr("wgt_rd_addr_o", wgt_rd_addr_o, cur_wgt_base + addr_t'(since - 1));
      end
      // Ready from the cycle after acceptance until K beats are in
      exp_rdy = tile_active && since >= 1 && beats_seen < cur_k;
      check_flag("dat_rdy_o", dat_rdy_o, exp_rdy);
      if (rd_addr_vld_o) begin
        act_q.push_back(act_rd_addr_o);
        wgt_q.push_back(wgt_rd_addr_o);
      end
      if (dat_vld_i && dat_rdy_o) begin
        void'(act_q.pop_front());
        void'(wgt_q.pop_front());
        beat_taken = 1'b1;
        beats_seen++;
      end
      // Stalled row must not move
      if (hold_pending) begin
        check_flag("ofm_vld_o", ofm_vld_o, 1'b1);
        check_addr("ofm_addr_o", ofm_addr_o, held_addr);
        for (int c = 0; c < NUM_COL; c++) begin
          check_ofm($sformatf("ofm_dat_o[%0d]", c), ofm_dat_o[c], held_dat[c]);
        end
      end
      hold_pending = ofm_vld_o && !ofm_rdy_i;
      held_addr    = ofm_addr_o;
      held_dat     = ofm_dat_o;
      if (ofm_vld_o && ofm_rdy_i) begin
        if (!tile_active || rows_seen >= NUM_ROW) begin
          $display("Output row written outside a tile at %0t", $time);
          other_errs++;
        end else begin
          check_addr("ofm_addr_o", ofm_addr_o, cur_ofm_base + addr_t'(rows_seen));
          for (int c = 0; c < NUM_COL; c++) begin
            check_ofm($sformatf("ofm_dat_o[%0d]", c), ofm_dat_o[c], exp_row[rows_seen][c]);
          end
          rows_seen++;
          if (rows_seen == NUM_ROW) begin
            tile_active = 1'b0;
            tiles_done++;
          end
        end
      end
    end
  end

  // Memory responder and output back-pressure
  always @(negedge clk) begin
    if (rst_n) begin
      ofm_rdy_i = ($urandom_range(9) >= 3);  // Low about 30 percent
      if (!dat_vld_i || beat_taken) begin
        beat_taken = 1'b0;
        if (act_q.size() > 0 && $urandom_range(3) != 0) begin
          act_dat_i = act_mem[act_q[0]];
          wgt_dat_i = wgt_mem[wgt_q[0]];
          dat_vld_i = 1'b1;
        end else begin
          dat_vld_i = 1'b0;
        end
      end
    end
  end

  initial begin
    cyc = 0;
    while (cyc < LIMIT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout after %0d cycles, %0d of %0d tiles finished", cyc, tiles_done,
             NUM_TILES);
    $display("FAIL: see errors above");
    $finish;
  end

  // ========================================
  // Tile sequence
  // ========================================
  initial begin
    void'($urandom(32'h3d0));
    rst_n = 1'b0;
    {cfg_vld_i, dat_vld_i, ofm_rdy_i} = '0;
    {cfg_chi_i, cfg_scale_i, cfg_shift_i, cfg_zp_i} = '0;
    {cfg_act_base_i, cfg_wgt_base_i, cfg_ofm_base_i} = '0;
    act_dat_i = '0;
    wgt_dat_i = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("cfg_rdy_o", cfg_rdy_o, 1'b1);
    check_flag("rd_addr_vld_o", rd_addr_vld_o, 1'b0);
    check_flag("dat_rdy_o", dat_rdy_o, 1'b0);
    check_flag("ofm_vld_o", ofm_vld_o, 1'b0);

    for (int t = 0; t < NUM_TILES; t++) begin
      while (!cfg_rdy_o) @(negedge clk);
      repeat ($urandom_range(2)) @(negedge clk);
      cur_k        = $urandom_range(16, 1);
      cur_act_base = addr_t'($urandom);
      cur_wgt_base = addr_t'($urandom);
      cur_ofm_base = addr_t'($urandom);
      cfg_scale_i  = scale_t'($urandom);
      cfg_shift_i  = shift_t'($urandom_range(12));
      cfg_zp_i     = zp_t'($urandom);
      if (t % 5 == 4) begin
        cfg_scale_i = '1;  // Drives most outputs into the clamp
        cfg_shift_i = '0;
      end
      fill_operands(cur_act_base, cur_wgt_base, cur_k);
      for (int r = 0; r < NUM_ROW; r++) begin
        for (int c = 0; c < NUM_COL; c++) begin
          exp_row[r][c] = requantize(dot_product(cur_act_base, cur_wgt_base, cur_k, r, c),
                                     cfg_scale_i, cfg_shift_i, cfg_zp_i);
        end
      end
      cfg_chi_i      = chi_t'(cur_k);
      cfg_act_base_i = cur_act_base;
      cfg_wgt_base_i = cur_wgt_base;
      cfg_ofm_base_i = cur_ofm_base;
      cfg_vld_i      = 1'b1;
      @(negedge clk);
      cfg_vld_i = 1'b0;
    end

    while (tiles_done < NUM_TILES) @(negedge clk);
    repeat (4) @(negedge clk);
    if (act_q.size() != 0) begin
      $display("Read addresses left without data at end of run");
      other_errs++;
    end
    check_flag("cfg_rdy_o", cfg_rdy_o, 1'b1);
    $display("Error counts: addr %0d, ofm %0d, flag %0d, other %0d",
             addr_errs, ofm_errs, flag_errs, other_errs);
    if (addr_errs + ofm_errs + flag_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- design/sa_core.sv
// Systolic array tile engine top
`timescale 1ns/10ps

module sa_core import sa_data_pkg::*; import sa_cfg_pkg::*; #(
  parameter int NUM_ROW = 4,
  parameter int NUM_COL = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_vld_i,
  output logic               cfg_rdy_o,
  input  chi_t               cfg_chi_i,
  input  scale_t             cfg_scale_i,
  input  shift_t             cfg_shift_i,
  input  zp_t                cfg_zp_i,
  input  addr_t              cfg_act_base_i,
  input  addr_t              cfg_wgt_base_i,
  input  addr_t              cfg_ofm_base_i,
  output addr_t              act_rd_addr_o,
  output addr_t              wgt_rd_addr_o,
  output logic               rd_addr_vld_o,
  input  act_t [NUM_ROW-1:0] act_dat_i,
  input  wgt_t [NUM_COL-1:0] wgt_dat_i,
  input  logic               dat_vld_i,
  output logic               dat_rdy_o,
  output ofm_t [NUM_COL-1:0] ofm_dat_o,
  output addr_t              ofm_addr_o,
  output logic               ofm_vld_o,
  input  logic               ofm_rdy_i
);

  wire take, clear, drain_start, tile_done;
  scale_t scale;
  shift_t shift;
  zp_t    zp;
  addr_t  ofm_base;

  act_t [NUM_ROW-1:0] act_skew;
  logic [NUM_ROW-1:0] act_skew_vld;
  wgt_t [NUM_COL-1:0] wgt_skew;
  logic [NUM_COL-1:0] wgt_skew_vld;

  wire wgt_t [NUM_COL-1:0] wgt_chain     [NUM_ROW];  // Weights leaving each row
  wire logic [NUM_COL-1:0] wgt_vld_chain [NUM_ROW];
  wire acc_t [NUM_ROW-1:0][NUM_COL-1:0] acc_all;

  tile_ctrl #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) tile_ctrl_inst (
    .clk, .rst_n, .cfg_vld_i, .cfg_chi_i, .cfg_scale_i, .cfg_shift_i, .cfg_zp_i,
    .cfg_act_base_i, .cfg_wgt_base_i, .cfg_ofm_base_i, .dat_vld_i,
    .tile_done_i(tile_done), .cfg_rdy_o, .act_rd_addr_o, .wgt_rd_addr_o,
    .rd_addr_vld_o, .dat_rdy_o, .take_o(take), .clear_o(clear),
    .drain_start_o(drain_start), .scale_o(scale), .shift_o(shift), .zp_o(zp),
    .ofm_base_o(ofm_base)
  );

  operand_skew #(.NUM_LANES(NUM_ROW), .lane_t(act_t)) act_skew_inst (
    .clk, .rst_n, .dat_i(act_dat_i), .take_i(take), .dat_o(act_skew), .vld_o(act_skew_vld)
  );

  operand_skew #(.NUM_LANES(NUM_COL), .lane_t(wgt_t)) wgt_skew_inst (
    .clk, .rst_n, .dat_i(wgt_dat_i), .take_i(take), .dat_o(wgt_skew), .vld_o(wgt_skew_vld)
  );

  // ========================================
  // Array rows
  // ========================================
  for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
    wire wgt_t [NUM_COL-1:0] wgt_in;
    wire logic [NUM_COL-1:0] wgt_vld_in;

    if (r == 0) begin : g_top
      assign wgt_in     = wgt_skew;
      assign wgt_vld_in = wgt_skew_vld;
    end else begin : g_below
      assign wgt_in     = wgt_chain[r-1];
      assign wgt_vld_in = wgt_vld_chain[r-1];
    end

    pe_row #(.NUM_COL(NUM_COL)) pe_row_inst (
      .clk, .rst_n, .clear_i(clear), .act_i(act_skew[r]), .act_vld_i(act_skew_vld[r]),
      .wgt_i(wgt_in), .wgt_vld_i(wgt_vld_in), .wgt_o(wgt_chain[r]),
      .wgt_vld_o(wgt_vld_chain[r]), .acc_o(acc_all[r])
    );
  end

  ofm_writer #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) ofm_writer_inst (
    .clk, .rst_n, .drain_start_i(drain_start), .acc_i(acc_all), .scale_i(scale),
    .shift_i(shift), .zp_i(zp), .ofm_base_i(ofm_base), .ofm_rdy_i, .ofm_dat_o,
    .ofm_addr_o, .ofm_vld_o, .tile_done_o(tile_done)
  );

endmodule

//--- design/ofm_writer.sv
// Output row quantizer and writer
`timescale 1ns/10ps

module ofm_writer import sa_data_pkg::*; import sa_cfg_pkg::*; #(
  parameter int NUM_ROW = 4,
  parameter int NUM_COL = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             drain_start_i,
  input  acc_t [NUM_ROW-1:0][NUM_COL-1:0]  acc_i,
  input  scale_t                           scale_i,
  input  shift_t                           shift_i,
  input  zp_t                              zp_i,
  input  addr_t                            ofm_base_i,
  input  logic                             ofm_rdy_i,
  output ofm_t [NUM_COL-1:0]               ofm_dat_o,
  output addr_t                            ofm_addr_o,
  output logic                             ofm_vld_o,
  output logic                             tile_done_o
);

  localparam int ROW_W      = $clog2(NUM_ROW);
  localparam int PROD_WIDTH = ACC_WIDTH + SCALE_WIDTH + 1;  // Room for the sign of scale

  logic [ROW_W-1:0] row_idx_q;
  logic             hshk;
  logic             last_row;

  // Scale, shift, offset and clamp one element
  function automatic ofm_t quantize(acc_t acc, scale_t scale, shift_t shift, zp_t zp);
    logic signed [PROD_WIDTH-1:0] prod;
    logic signed [PROD_WIDTH-1:0] sum;
    prod = acc * $signed({1'b0, scale});
    sum  = (prod >>> shift) + zp;
    if (sum > OFM_MAX) begin
      return ofm_t'(OFM_MAX);
    end else if (sum < OFM_MIN) begin
      return ofm_t'(OFM_MIN);
    end
    return ofm_t'(sum);
  endfunction

  assign hshk        = ofm_vld_o && ofm_rdy_i;
  assign last_row    = (row_idx_q == ROW_W'(NUM_ROW - 1));
  assign tile_done_o = hshk && last_row;
  assign ofm_addr_o  = ofm_base_i + addr_t'(row_idx_q);

  // ========================================
  // Row stepping
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_idx_q <= '0;
      ofm_vld_o <= 1'b0;
    end else if (drain_start_i) begin
      row_idx_q <= '0;
      ofm_vld_o <= 1'b1;
    end else if (hshk) begin
      if (last_row) begin
        ofm_vld_o <= 1'b0;  // Tile finished
      end else begin
        row_idx_q <= row_idx_q + 1'b1;
      end
    end
  end

  // Accumulators are frozen during the write phase
  for (genvar c = 0; c < NUM_COL; c++) begin : g_quant
    assign ofm_dat_o[c] = quantize(acc_i[row_idx_q][c], scale_i, shift_i, zp_i);
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ofm_vld_o && !ofm_rdy_i |=> $stable(ofm_dat_o) && $stable(ofm_addr_o));

endmodule

//--- design/pe_row.sv
// Row of multiply-accumulate cells
`timescale 1ns/10ps

module pe_row import sa_data_pkg::*; #(
  parameter int NUM_COL = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_i,
  input  act_t                 act_i,
  input  logic                 act_vld_i,
  input  wgt_t [NUM_COL-1:0]   wgt_i,
  input  logic [NUM_COL-1:0]   wgt_vld_i,
  output wgt_t [NUM_COL-1:0]   wgt_o,
  output logic [NUM_COL-1:0]   wgt_vld_o,
  output acc_t [NUM_COL-1:0]   acc_o
);

  act_t [NUM_COL-1:0] act_in;      // Activation seen by each cell
  logic [NUM_COL-1:0] act_vld_in;
  act_t [NUM_COL-2:0] act_q;       // Right-going pipeline
  logic [NUM_COL-2:0] act_vld_q;

  // ========================================
  // Activation path
  // ========================================
  assign act_in[0]     = act_i;
  assign act_vld_in[0] = act_vld_i;

  for (genvar c = 1; c < NUM_COL; c++) begin : g_act_tap
    assign act_in[c]     = act_q[c-1];
    assign act_vld_in[c] = act_vld_q[c-1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      act_vld_q <= '0;
    end else begin
      act_vld_q <= act_vld_in[NUM_COL-2:0];
    end
  end

  always_ff @(posedge clk) begin
    act_q <= act_in[NUM_COL-2:0];
  end

  // Weights drop one row per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_vld_o <= '0;
    end else begin
      wgt_vld_o <= wgt_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    wgt_o <= wgt_i;
  end

  // ========================================
  // Accumulators
  // ========================================
  for (genvar c = 0; c < NUM_COL; c++) begin : g_cell
    acc_t prod;

    assign prod = act_in[c] * wgt_i[c];  // Sign-extended to accumulator width

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc_o[c] <= '0;
      end else if (clear_i) begin
        acc_o[c] <= '0;
      end else if (act_vld_in[c] && wgt_vld_i[c]) begin
        acc_o[c] <= acc_o[c] + prod;
      end
    end
  end

endmodule

//--- design/operand_skew.sv
// Operand staggering delay lines
`timescale 1ns/10ps

module operand_skew #(
  parameter int  NUM_LANES = 4,
  parameter type lane_t    = logic [7:0]
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  lane_t [NUM_LANES-1:0] dat_i,
  input  logic                  take_i,
  output lane_t [NUM_LANES-1:0] dat_o,
  output logic  [NUM_LANES-1:0] vld_o
);

  // Lane i sits i cycles behind lane 0 so that
  // operands meet on the array diagonals
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign dat_o[i] = dat_i[i];
      assign vld_o[i] = take_i;
    end else begin : g_delay
      lane_t          dat_q [i];
      logic   [i-1:0] vld_q;

      // Valid stages
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          vld_q <= '0;
        end else begin
          vld_q[0] <= take_i;
          for (int j = 1; j < i; j++) begin
            vld_q[j] <= vld_q[j-1];
          end
        end
      end

      // Data stages follow the valid without enable
      always_ff @(posedge clk) begin
        dat_q[0] <= dat_i[i];
        for (int j = 1; j < i; j++) begin
          dat_q[j] <= dat_q[j-1];
        end
      end

      assign dat_o[i] = dat_q[i-1];
      assign vld_o[i] = vld_q[i-1];
    end
  end

endmodule

//--- design/tile_ctrl.sv
// Tile sequencing controller
`timescale 1ns/10ps

module tile_ctrl import sa_cfg_pkg::*; #(
  parameter int NUM_ROW = 4,
  parameter int NUM_COL = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cfg_vld_i,
  input  chi_t   cfg_chi_i,
  input  scale_t cfg_scale_i,
  input  shift_t cfg_shift_i,
  input  zp_t    cfg_zp_i,
  input  addr_t  cfg_act_base_i,
  input  addr_t  cfg_wgt_base_i,
  input  addr_t  cfg_ofm_base_i,
  input  logic   dat_vld_i,
  input  logic   tile_done_i,
  output logic   cfg_rdy_o,
  output addr_t  act_rd_addr_o,
  output addr_t  wgt_rd_addr_o,
  output logic   rd_addr_vld_o,
  output logic   dat_rdy_o,
  output logic   take_o,
  output logic   clear_o,
  output logic   drain_start_o,
  output scale_t scale_o,
  output shift_t shift_o,
  output zp_t    zp_o,
  output addr_t  ofm_base_o
);

  // Last operand pair reaches the far corner cell within this many cycles
  localparam int DRAIN_CYC = NUM_ROW + NUM_COL;
  localparam int DRAIN_W   = $clog2(DRAIN_CYC + 1);

  typedef enum logic [1:0] {S_IDLE, S_FILL, S_DRAIN, S_WRITE} state_t;

  state_t             state_q;
  chi_t               chi_q;
  addr_t              act_base_q;
  addr_t              wgt_base_q;
  chi_t               addr_cnt_q;   // Addresses issued so far
  logic               addr_vld_q;
  chi_t               beat_cnt_q;   // Data beats taken so far
  logic [DRAIN_W-1:0] drain_cnt_q;
  logic               drain_start_q;
  logic               cfg_acc;
  logic               last_beat;
  logic               drain_done;

  assign cfg_rdy_o  = (state_q == S_IDLE);
  assign cfg_acc    = cfg_vld_i && cfg_rdy_o;
  assign dat_rdy_o  = (state_q == S_FILL);
  assign take_o     = dat_vld_i && dat_rdy_o;
  assign clear_o    = cfg_acc;  // Global accumulator clear
  assign last_beat  = take_o && (beat_cnt_q == chi_q - 1'b1);
  assign drain_done = (state_q == S_DRAIN) && (drain_cnt_q == DRAIN_W'(DRAIN_CYC - 1));

  assign act_rd_addr_o = act_base_q + addr_t'(addr_cnt_q);
  assign wgt_rd_addr_o = wgt_base_q + addr_t'(addr_cnt_q);
  assign rd_addr_vld_o = addr_vld_q;
  assign drain_start_o = drain_start_q;

  // ========================================
  // State machine
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (cfg_acc)     state_q <= S_FILL;
        S_FILL:  if (last_beat)   state_q <= S_DRAIN;
        S_DRAIN: if (drain_done)  state_q <= S_WRITE;
        S_WRITE: if (tile_done_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Configuration capture
  always_ff @(posedge clk) begin
    if (cfg_acc) begin
      chi_q      <= cfg_chi_i;
      act_base_q <= cfg_act_base_i;
      wgt_base_q <= cfg_wgt_base_i;
      ofm_base_o <= cfg_ofm_base_i;
      scale_o    <= cfg_scale_i;
      shift_o    <= cfg_shift_i;
      zp_o       <= cfg_zp_i;
    end
  end

  // ========================================
  // Counters
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_cnt_q <= '0;
      addr_vld_q <= 1'b0;
    end else if (cfg_acc) begin
      addr_cnt_q <= '0;
      addr_vld_q <= 1'b1;
    end else if (addr_vld_q) begin
      if (addr_cnt_q == chi_q - 1'b1) begin
        addr_vld_q <= 1'b0;  // K strobes issued
      end else begin
        addr_cnt_q <= addr_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q    <= '0;
      drain_cnt_q   <= '0;
      drain_start_q <= 1'b0;
    end else begin
      if (cfg_acc) begin
        beat_cnt_q <= '0;
      end else if (take_o) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      drain_cnt_q   <= (state_q == S_DRAIN) ? drain_cnt_q + 1'b1 : '0;
      drain_start_q <= drain_done;
    end
  end

  a_beats_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    take_o |-> beat_cnt_q < chi_q);

  a_chi_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_acc |-> cfg_chi_i != '0);

endmodule

//--- design/sa_cfg_pkg.sv
// Tile configuration field types
package sa_cfg_pkg;

  // ========================================
  // Depth and addressing
  // ========================================

  localparam int CHI_WIDTH  = 10;  // Accumulation depth K
  localparam int ADDR_WIDTH = 16;  // Buffer word address

  typedef logic [CHI_WIDTH-1:0]  chi_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // ========================================
  // Quantization
  // ========================================

  localparam int SCALE_WIDTH = 8;
  localparam int SHIFT_WIDTH = 5;
  localparam int ZP_WIDTH    = 8;

  // Unsigned multiplier applied to the accumulator
  typedef logic [SCALE_WIDTH-1:0] scale_t;

  // Arithmetic right shift after scaling
  typedef logic [SHIFT_WIDTH-1:0] shift_t;

  // Signed offset added before saturation
  typedef logic signed [ZP_WIDTH-1:0] zp_t;

endpackage

//--- design/sa_data_pkg.sv
// Datapath number types
package sa_data_pkg;

  // ========================================
  // Operand widths
  // ========================================

  localparam int ACT_WIDTH = 8;  // Activation lane
  localparam int WGT_WIDTH = 8;  // Weight lane

  // Product width plus headroom for up to 1023 accumulation steps
  localparam int ACC_WIDTH = ACT_WIDTH + WGT_WIDTH + 10;

  // ========================================
  // Number types
  // ========================================

  // Signed activation entering the array from the left
  typedef logic signed [ACT_WIDTH-1:0] act_t;

  // Signed weight entering the array from the top
  typedef logic signed [WGT_WIDTH-1:0] wgt_t;

  // Per-cell running sum
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // Quantized output element as wide as an activation
  typedef logic signed [ACT_WIDTH-1:0] ofm_t;

  // Saturation bounds of a quantized element
  localparam int OFM_MAX = 127;
  localparam int OFM_MIN = -128;

endpackage
